//--- lsuParamPkg.sv
package lsuParamPkg;

  // queue depths, one entry per in-flight load or store
  localparam int lqSize = 8;
  localparam int sqSize = 8;

  // index width covering either queue
  localparam int lsqIdBits = 3;

  // word addressed memory, 1K words
  localparam int addrBits = 10;

  // whole-word accesses only
  localparam int dataBits = 32;

endpackage

//--- lsuTypesPkg.sv
package lsuTypesPkg;

  import lsuParamPkg::*;

  // queue index, wraps modulo queue depth
  typedef logic [lsqIdBits-1:0] lsqIdT;

  // occupancy, one extra bit so a full queue is representable
  typedef logic [lsqIdBits:0] lsqCountT;

  // data word
  typedef logic [dataBits-1:0] wordT;

  // word address
  typedef logic [addrBits-1:0] addrT;

  // one bit per store queue entry
  typedef logic [sqSize-1:0] sqMaskT;

endpackage

//--- lsqAlloc.sv
module lsqAlloc
  import lsuParamPkg::*, lsuTypesPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dispatchValid_i,
  input  logic     dispatchIsLoad_i,
  output logic     dispatchReady_o,
  output lsqIdT    lsqId_o,
  input  logic     commitLoad_i,
  input  logic     stFree_i,
  input  logic     wbLoadValid_i,
  input  lsqIdT    wbLoadId_i,
  input  lsqIdT    lookupLdId_i,
  output lsqIdT    lookupStTail_o,
  output lsqIdT    stqHead_o,
  output lsqIdT    stqTail_o,
  output lsqCountT ldqCount_o,
  output lsqCountT stqCount_o
);

  lsqIdT    ldqHead, ldqTail;
  lsqIdT    stqHead, stqTail;
  lsqCountT ldqCount, stqCount;
  logic     outOfReset;             // held low for the first cycle after reset
  logic     ldFull, stFull;
  logic     ldPush, stPush;
  lsqIdT    ldStTail [lqSize];      // store tail seen by each load at dispatch
  logic [lqSize-1:0] ldWb;          // load has written back

  assign ldFull = (ldqCount == lsqCountT'(lqSize));
  assign stFull = (stqCount == lsqCountT'(sqSize));

  // ready depends on which queue the op targets
  assign dispatchReady_o = outOfReset & ~(dispatchIsLoad_i ? ldFull : stFull);
  assign lsqId_o         = dispatchIsLoad_i ? ldqTail : stqTail; // id known same cycle

  assign ldPush = dispatchValid_i & dispatchReady_o & dispatchIsLoad_i;
  assign stPush = dispatchValid_i & dispatchReady_o & ~dispatchIsLoad_i;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      outOfReset <= 1'b0;
      ldqHead    <= '0;
      ldqTail    <= '0;
      stqHead    <= '0;
      stqTail    <= '0;
      ldqCount   <= '0;
      stqCount   <= '0;
      ldWb       <= '0;
    end
    else
    begin
      outOfReset <= 1'b1;
      if (ldPush)
      begin
        ldqTail       <= ldqTail + 1'b1;
        ldWb[ldqTail] <= 1'b0;            // fresh load, nothing written back yet
      end
      if (wbLoadValid_i)
        ldWb[wbLoadId_i] <= 1'b1;
      if (commitLoad_i)
        ldqHead <= ldqHead + 1'b1;
      if (stPush)
        stqTail <= stqTail + 1'b1;
      if (stFree_i)
        stqHead <= stqHead + 1'b1;        // head store acked by memory
      ldqCount <= ldqCount + lsqCountT'(ldPush) - lsqCountT'(commitLoad_i);
      stqCount <= stqCount + lsqCountT'(stPush) - lsqCountT'(stFree_i);
    end
  end

  // snapshot of store tail marks where older stores end
  always_ff @(posedge clk)
  begin
    if (ldPush)
      ldStTail[ldqTail] <= stqTail;
  end

  assign lookupStTail_o = ldStTail[lookupLdId_i];
  assign stqHead_o      = stqHead;
  assign stqTail_o      = stqTail;
  assign ldqCount_o     = ldqCount;
  assign stqCount_o     = stqCount;

  // a load retires only once it is in the queue and has produced its result
  commitLoadLegal: assert property (@(posedge clk) disable iff (reset)
    commitLoad_i |-> (ldqCount != '0) && ldWb[ldqHead])
    else $error("commitLoad_i on empty queue or load not written back");

endmodule

//--- storeQueue.sv
module storeQueue
  import lsuParamPkg::*, lsuTypesPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   wrValid_i,
  input  lsqIdT  wrId_i,
  input  addrT   wrAddr_i,
  input  wordT   wrData_i,
  input  logic   allocValid_i,
  input  lsqIdT  allocId_i,
  input  addrT   searchAddr_i,
  output sqMaskT matchVec_o,
  input  lsqIdT  readId_i,
  output wordT   readData_o,
  input  lsqIdT  stqHead_i,
  input  logic   commitStore_i,
  output logic   memWrValid_o,
  output addrT   memWrAddr_o,
  output wordT   memWrData_o,
  input  logic   memWrDone_i,
  output logic   stFree_o,
  output logic   stCommitStall_o
);

  addrT   stAddr [sqSize];      // address ram
  wordT   stData [sqSize];      // data ram
  sqMaskT addrKnown;            // agen has delivered the address
  sqMaskT committed;            // retired, waiting on memory

  always_ff @(posedge clk)
  begin
    if (wrValid_i)
    begin
      stAddr[wrId_i] <= wrAddr_i;
      stData[wrId_i] <= wrData_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      addrKnown <= '0;
      committed <= '0;
    end
    else
    begin
      if (allocValid_i)
      begin
        addrKnown[allocId_i] <= 1'b0;   // new store, address not yet known
        committed[allocId_i] <= 1'b0;
      end
      if (wrValid_i)
        addrKnown[wrId_i] <= 1'b1;
      if (commitStore_i)
        committed[stqHead_i] <= 1'b1;
      if (stFree_o)
      begin
        // freed entry drops out of the search right away
        addrKnown[stqHead_i] <= 1'b0;
        committed[stqHead_i] <= 1'b0;
      end
    end
  end

  // cam over entries with a known address
  always_comb
  begin
    for (int i = 0; i < sqSize; i++)
      matchVec_o[i] = addrKnown[i] && (stAddr[i] == searchAddr_i);
  end

  assign readData_o = stData[readId_i]; // forwarding read port

  // head is drained in place, request held until the ack
  assign memWrValid_o    = committed[stqHead_i];
  assign memWrAddr_o     = stAddr[stqHead_i];
  assign memWrData_o     = stData[stqHead_i];
  assign stFree_o        = memWrValid_o & memWrDone_i;
  assign stCommitStall_o = committed[stqHead_i]; // one store in the write path at a time

  // retire only into an idle write path with a resolved head address
  commitStoreLegal: assert property (@(posedge clk) disable iff (reset)
    commitStore_i |-> !stCommitStall_o && addrKnown[stqHead_i])
    else $error("commitStore_i while stalled or head address unknown");

endmodule

//--- lsuAgenStage.sv
module lsuAgenStage
  import lsuParamPkg::*, lsuTypesPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   agenValid_i,
  input  logic   agenIsLoad_i,
  input  lsqIdT  agenLsqId_i,
  input  addrT   agenAddr_i,
  input  wordT   agenData_i,
  output logic   agenReady_o,
  input  logic   stall_i,
  input  lsqIdT  stqHead_i,
  input  lsqIdT  ldStTail_i,
  output logic   sqWrValid_o,
  output logic   s1Valid_o,
  output logic   s1IsLoad_o,
  output lsqIdT  s1LsqId_o,
  output addrT   s1Addr_o,
  output sqMaskT s1OlderMask_o
);

  logic   accept;
  sqMaskT olderMask;

  assign agenReady_o = ~stall_i;                 // back-pressure from memory stage
  assign accept      = agenValid_i & agenReady_o;
  assign sqWrValid_o = accept & ~agenIsLoad_i;   // store fills its entry at accept
  // agenData_i goes straight to the store queue data port

  // entries in [head, tail) are older than the load
  always_comb
  begin : buildMask
    lsqIdT span;
    lsqIdT rel;
    span = ldStTail_i - stqHead_i;               // wraps mod queue depth
    for (int i = 0; i < sqSize; i++)
    begin
      rel          = lsqIdT'(i) - stqHead_i;
      olderMask[i] = agenIsLoad_i && (rel < span);
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      s1Valid_o <= 1'b0;
    else if (!stall_i)
      s1Valid_o <= accept;
  end

  always_ff @(posedge clk)
  begin
    if (!stall_i && accept)
    begin
      s1IsLoad_o    <= agenIsLoad_i;
      s1LsqId_o     <= agenLsqId_i;
      s1Addr_o      <= agenAddr_i;
      s1OlderMask_o <= olderMask;
    end
  end

endmodule

//--- lsuForwardStage.sv
module lsuForwardStage
  import lsuParamPkg::*, lsuTypesPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   stall_i,
  input  logic   s1Valid_i,
  input  logic   s1IsLoad_i,
  input  lsqIdT  s1LsqId_i,
  input  addrT   s1Addr_i,
  input  sqMaskT s1OlderMask_i,
  input  lsqIdT  stqHead_i,
  input  sqMaskT matchVec_i,
  output lsqIdT  readId_o,
  input  wordT   readData_i,
  output logic   s2Valid_o,
  output logic   s2IsLoad_o,
  output logic   s2Hit_o,
  output lsqIdT  s2LsqId_o,
  output addrT   s2Addr_o,
  output wordT   s2Data_o
);

  sqMaskT hitVec;
  logic   hitFound;
  lsqIdT  hitId;

  assign hitVec = matchVec_i & s1OlderMask_i; // same address and older than the load

  // walk from the oldest live store toward the youngest
  // last hit seen is the youngest older store
  always_comb
  begin : pickYoungest
    lsqIdT idx;
    hitFound = 1'b0;
    hitId    = stqHead_i;
    for (int k = 0; k < sqSize; k++)
    begin
      idx = stqHead_i + lsqIdT'(k);
      if (hitVec[idx])
      begin
        hitFound = 1'b1;
        hitId    = idx;
      end
    end
  end

  assign readId_o = hitId; // data ram read of the forwarding entry

  always_ff @(posedge clk)
  begin
    if (reset)
      s2Valid_o <= 1'b0;
    else if (!stall_i)
      s2Valid_o <= s1Valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (!stall_i && s1Valid_i)
    begin
      s2IsLoad_o <= s1IsLoad_i;
      s2LsqId_o  <= s1LsqId_i;
      s2Addr_o   <= s1Addr_i;
      s2Hit_o    <= s1IsLoad_i & hitFound;  // stores never hit
      s2Data_o   <= readData_i;
    end
  end

endmodule

//--- lsuMemStage.sv
module lsuMemStage
  import lsuTypesPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  s2Valid_i,
  input  logic  s2IsLoad_i,
  input  logic  s2Hit_i,
  input  lsqIdT s2LsqId_i,
  input  addrT  s2Addr_i,
  input  wordT  s2Data_i,
  output logic  stall_o,
  output logic  memRdValid_o,
  output addrT  memRdAddr_o,
  input  wordT  memRdData_i,
  input  logic  memRdDataValid_i,
  output logic  wbValid_o,
  output logic  wbIsLoad_o,
  output logic  wbForwarded_o,
  output lsqIdT wbLsqId_o,
  output wordT  wbData_o
);

  logic  take;      // s2 item consumed this cycle
  logic  miss;      // load needs a memory read
  logic  rdDone;    // response for the outstanding read
  lsqIdT rdLsqId;   // id of the load waiting on memory

  // held for the whole read including the response edge so only one wb per edge
  assign stall_o = memRdValid_o;
  assign take    = s2Valid_i & ~stall_o;
  assign miss    = take & s2IsLoad_i & ~s2Hit_i;
  assign rdDone  = memRdValid_o & memRdDataValid_i;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wbValid_o    <= 1'b0;
      memRdValid_o <= 1'b0;
    end
    else
    begin
      wbValid_o <= rdDone | (take & ~miss); // single cycle pulse
      if (rdDone)
        memRdValid_o <= 1'b0;
      else if (miss)
        memRdValid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rdDone)
    begin
      wbIsLoad_o    <= 1'b1;
      wbForwarded_o <= 1'b0;
      wbLsqId_o     <= rdLsqId;
      wbData_o      <= memRdData_i;
    end
    else if (take && !miss)
    begin
      wbIsLoad_o    <= s2IsLoad_i;
      wbForwarded_o <= s2IsLoad_i;          // load here implies a store queue hit
      wbLsqId_o     <= s2LsqId_i;
      wbData_o      <= s2IsLoad_i ? s2Data_i : '0;
    end
    if (miss)
    begin
      memRdAddr_o <= s2Addr_i;
      rdLsqId     <= s2LsqId_i;
    end
  end

  // memory answers only a read that is still outstanding
  rdRespExpected: assert property (@(posedge clk) disable iff (reset)
    memRdDataValid_i |-> memRdValid_o)
    else $error("memRdDataValid_i without an outstanding read");

endmodule

//--- lsuTop.sv
module lsuTop
  import lsuTypesPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dispatchValid_i,
  input  logic     dispatchIsLoad_i,
  output logic     dispatchReady_o,
  output lsqIdT    lsqId_o,
  input  logic     agenValid_i,
  input  logic     agenIsLoad_i,
  input  lsqIdT    agenLsqId_i,
  input  addrT     agenAddr_i,
  input  wordT     agenData_i,
  output logic     agenReady_o,
  output logic     wbValid_o,
  output logic     wbIsLoad_o,
  output lsqIdT    wbLsqId_o,
  output wordT     wbData_o,
  output logic     wbForwarded_o,
  input  logic     commitLoad_i,
  input  logic     commitStore_i,
  output logic     stCommitStall_o,
  output logic     memRdValid_o,
  output addrT     memRdAddr_o,
  input  wordT     memRdData_i,
  input  logic     memRdDataValid_i,
  output logic     memWrValid_o,
  output addrT     memWrAddr_o,
  output wordT     memWrData_o,
  input  logic     memWrDone_i,
  output lsqCountT ldqCount_o,
  output lsqCountT stqCount_o
);

  lsqIdT  stqHead, stqTail, ldStTail, readId;
  logic   stFree, sqWrValid, stallMem, stAlloc, wbLoadValid;
  sqMaskT matchVec, s1OlderMask;
  wordT   readData, s2Data;
  logic   s1Valid, s1IsLoad, s2Valid, s2IsLoad, s2Hit;
  lsqIdT  s1LsqId, s2LsqId;
  addrT   s1Addr, s2Addr;

  assign stAlloc     = dispatchValid_i & dispatchReady_o & ~dispatchIsLoad_i;
  assign wbLoadValid = wbValid_o & wbIsLoad_o;   // feeds written-back bits

  lsqAlloc allocU (
    .clk, .reset, .dispatchValid_i, .dispatchIsLoad_i, .dispatchReady_o, .lsqId_o,
    .commitLoad_i, .stFree_i(stFree), .wbLoadValid_i(wbLoadValid), .wbLoadId_i(wbLsqId_o),
    .lookupLdId_i(agenLsqId_i), .lookupStTail_o(ldStTail), .stqHead_o(stqHead),
    .stqTail_o(stqTail), .ldqCount_o, .stqCount_o
  );

  storeQueue sqU (
    .clk, .reset, .wrValid_i(sqWrValid), .wrId_i(agenLsqId_i), .wrAddr_i(agenAddr_i),
    .wrData_i(agenData_i), .allocValid_i(stAlloc), .allocId_i(stqTail),
    .searchAddr_i(s1Addr), .matchVec_o(matchVec), .readId_i(readId), .readData_o(readData),
    .stqHead_i(stqHead), .commitStore_i, .memWrValid_o, .memWrAddr_o, .memWrData_o,
    .memWrDone_i, .stFree_o(stFree), .stCommitStall_o
  );

  lsuAgenStage agenU (
    .clk, .reset, .agenValid_i, .agenIsLoad_i, .agenLsqId_i, .agenAddr_i, .agenData_i,
    .agenReady_o, .stall_i(stallMem), .stqHead_i(stqHead), .ldStTail_i(ldStTail),
    .sqWrValid_o(sqWrValid), .s1Valid_o(s1Valid), .s1IsLoad_o(s1IsLoad),
    .s1LsqId_o(s1LsqId), .s1Addr_o(s1Addr), .s1OlderMask_o(s1OlderMask)
  );

  lsuForwardStage fwdU (
    .clk, .reset, .stall_i(stallMem), .s1Valid_i(s1Valid), .s1IsLoad_i(s1IsLoad),
    .s1LsqId_i(s1LsqId), .s1Addr_i(s1Addr), .s1OlderMask_i(s1OlderMask),
    .stqHead_i(stqHead), .matchVec_i(matchVec), .readId_o(readId), .readData_i(readData),
    .s2Valid_o(s2Valid), .s2IsLoad_o(s2IsLoad), .s2Hit_o(s2Hit), .s2LsqId_o(s2LsqId),
    .s2Addr_o(s2Addr), .s2Data_o(s2Data)
  );

  lsuMemStage memU (
    .clk, .reset, .s2Valid_i(s2Valid), .s2IsLoad_i(s2IsLoad), .s2Hit_i(s2Hit),
    .s2LsqId_i(s2LsqId), .s2Addr_i(s2Addr), .s2Data_i(s2Data), .stall_o(stallMem),
    .memRdValid_o, .memRdAddr_o, .memRdData_i, .memRdDataValid_i,
    .wbValid_o, .wbIsLoad_o, .wbForwarded_o, .wbLsqId_o, .wbData_o
  );

endmodule

//--- lsuTb.sv
module lsuTb
  import lsuParamPkg::*, lsuTypesPkg::*;
();

  localparam int numBatches    = 40;
  localparam int maxBatch      = 17;                  // upper bound on ops per batch
  localparam int maxOps        = numBatches * maxBatch;
  localparam int clkPeriod     = 40;
  localparam int watchdogLimit = (maxOps * 40 + 200) * clkPeriod;
  localparam int poolBase      = 'h3c0;               // hot region for address matches

  logic     clk = 1'b0;
  logic     reset;
  logic     dispatchValid_i, dispatchIsLoad_i, dispatchReady_o;
  lsqIdT    lsqId_o;
  logic     agenValid_i, agenIsLoad_i, agenReady_o;
  lsqIdT    agenLsqId_i;
  addrT     agenAddr_i;
  wordT     agenData_i;
  logic     wbValid_o, wbIsLoad_o, wbForwarded_o;
  lsqIdT    wbLsqId_o;
  wordT     wbData_o;
  logic     commitLoad_i, commitStore_i, stCommitStall_o;
  logic     memRdValid_o, memRdDataValid_i;
  addrT     memRdAddr_o;
  wordT     memRdData_i;
  logic     memWrValid_o, memWrDone_i;
  addrT     memWrAddr_o;
  wordT     memWrData_o;
  lsqCountT ldqCount_o, stqCount_o;

  integer seed = 91;

  // program-order record of every op
  logic  opIsLoad   [maxOps];
  lsqIdT opId       [maxOps];
  addrT  opAddr     [maxOps];
  wordT  opData     [maxOps];
  bit    opAgenSent [maxOps];
  int    opAgenSeq  [maxOps];                         // acceptance order of agen
  int    opAccCycle [maxOps];
  int    opAccStall [maxOps];
  bit    opWb       [maxOps];
  bit    opFreed    [maxOps];
  int    ldPosOf    [lqSize];                         // queue id to list position
  int    stPosOf    [sqSize];
  wordT  memModel   [1 << addrBits];
  int    wrOrder    [$];                              // committed stores awaiting the write

  int    opCount = 0, wbCount = 0, agenSeq = 0, cycleNo = 0, stallEdges = 0;
  int    ldCnt = 0, stCnt = 0, fwdCount = 0, memLoadCount = 0;
  lsqIdT ldNext = '0, stNext = '0;

  lsuTop dut_i (.*);

  always #(clkPeriod / 2) clk = ~clk;

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("ERROR at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic reportProblem(input string what);
    $display("ERROR at time %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  // {forwarded, data} for the load at list position pos
  function automatic logic [32:0] expectedLoad(input int pos);
    logic [32:0] res;
    logic        found;
    res   = {1'b0, memModel[opAddr[pos]]};
    found = 1'b0;
    for (int p = pos - 1; p >= 0 && !found; p--)
    begin
      // youngest older store still queued whose agen preceded this load's
      if (!opIsLoad[p] && !opFreed[p] && opAgenSent[p] && opAddr[p] == opAddr[pos]
          && opAgenSeq[p] < opAgenSeq[pos])
      begin
        res   = {1'b1, opData[p]};
        found = 1'b1;
      end
    end
    return res;
  endfunction

  function automatic addrT pickAddr();
    if (($random(seed) & 3) == 0)
      return addrT'($random(seed));                   // anywhere so rarely matches
    return addrT'(poolBase + ($unsigned($random(seed)) % 8));
  endfunction

  task automatic checkCounts();
    assert (ldqCount_o == lsqCountT'(ldCnt))
      else reportMismatch("ldqCount_o", 32'(ldqCount_o), 32'(ldCnt));
    assert (stqCount_o == lsqCountT'(stCnt))
      else reportMismatch("stqCount_o", 32'(stqCount_o), 32'(stCnt));
  endtask

  task automatic checkIdle();
    assert (!wbValid_o) else reportMismatch("wbValid_o", 32'(wbValid_o), 0);
    assert (!memRdValid_o) else reportMismatch("memRdValid_o", 32'(memRdValid_o), 0);
    assert (!memWrValid_o) else reportMismatch("memWrValid_o", 32'(memWrValid_o), 0);
    assert (!stCommitStall_o) else reportMismatch("stCommitStall_o", 32'(stCommitStall_o), 0);
    checkCounts();
  endtask

  // called at +5 and returns at +5 of the next cycle
  task automatic dispatchOne(input logic isLoad);
    logic  expReady;
    lsqIdT expId;
    expReady = isLoad ? (ldCnt != lqSize) : (stCnt != sqSize);
    expId    = isLoad ? ldNext : stNext;
    dispatchValid_i  = 1'b1;
    dispatchIsLoad_i = isLoad;
    #1;                                               // let ready and id settle
    assert (dispatchReady_o == expReady)
      else reportMismatch("dispatchReady_o", 32'(dispatchReady_o), 32'(expReady));
    if (expReady)
      assert (lsqId_o == expId) else reportMismatch("lsqId_o", 32'(lsqId_o), 32'(expId));
    checkCounts();
    @(posedge clk);
    #5;
    dispatchValid_i = 1'b0;
    if (expReady)
    begin
      opIsLoad[opCount] = isLoad;
      opId[opCount]     = expId;
      opAddr[opCount]   = pickAddr();
      opData[opCount]   = wordT'($random(seed));
      if (isLoad)
      begin
        ldPosOf[expId] = opCount;
        ldNext++;
        ldCnt++;
      end
      else
      begin
        stPosOf[expId] = opCount;
        stNext++;
        stCnt++;
      end
      opCount++;
    end
  endtask

  task automatic sendAgen(input int pos);
    logic ready;
    agenValid_i  = 1'b1;
    agenIsLoad_i = opIsLoad[pos];
    agenLsqId_i  = opId[pos];
    agenAddr_i   = opAddr[pos];
    agenData_i   = opIsLoad[pos] ? '0 : opData[pos];
    do
    begin
      ready = agenReady_o;                            // only moves on a clock edge
      @(posedge clk);
      #5;
    end while (!ready);
    agenValid_i = 1'b0;
  endtask

  // retire positions first..last-1 in program order
  task automatic commitBatch(input int first, input int last);
    for (int p = first; p < last; p++)
    begin
      if (opIsLoad[p])
      begin
        commitLoad_i = 1'b1;
        @(posedge clk);
        #5;
        commitLoad_i = 1'b0;
        ldCnt--;
      end
      else
      begin
        while (stCommitStall_o)
        begin
          @(posedge clk);
          #5;
        end
        wrOrder.push_back(p);
        commitStore_i = 1'b1;
        @(posedge clk);
        #5;
        commitStore_i = 1'b0;
      end
    end
    while (stCnt != 0)
    begin
      @(posedge clk);
      #5;
    end
  endtask

  // outputs sampled mid cycle
  always @(negedge clk)
  begin : compareWb
    int          pos;
    logic [32:0] want;
    if (!reset)
    begin
      // agen is held off exactly while a read is outstanding
      assert (agenReady_o == !memRdValid_o)
        else reportMismatch("agenReady_o", 32'(agenReady_o), 32'(!memRdValid_o));
      if (wbValid_o)
      begin
        pos = wbIsLoad_o ? ldPosOf[wbLsqId_o] : stPosOf[wbLsqId_o];
        assert (opAgenSent[pos] && !opWb[pos])
          else reportProblem("writeback for an identifier that is not in flight");
        want = wbIsLoad_o ? expectedLoad(pos) : 33'd0;  // stores carry zero
        assert (wbData_o == want[31:0]) else reportMismatch("wbData_o", wbData_o, want[31:0]);
        assert (wbForwarded_o == want[32])
          else reportMismatch("wbForwarded_o", 32'(wbForwarded_o), 32'(want[32]));
        // no stall since acceptance means wb two edges after it
        if ((want[32] || !wbIsLoad_o) && stallEdges == opAccStall[pos])
          assert (cycleNo == opAccCycle[pos] + 3)
            else reportMismatch("wbValid_o delay", 32'(cycleNo - opAccCycle[pos] - 1), 2);
        if (wbIsLoad_o && want[32])
          fwdCount++;
        else if (wbIsLoad_o)
          memLoadCount++;
        opWb[pos] = 1'b1;
        wbCount++;
      end
      if (agenValid_i && agenReady_o)
      begin
        pos = agenIsLoad_i ? ldPosOf[agenLsqId_i] : stPosOf[agenLsqId_i];
        opAgenSent[pos] = 1'b1;
        opAgenSeq[pos]  = agenSeq;
        agenSeq++;
        opAccCycle[pos] = cycleNo;
        opAccStall[pos] = stallEdges;
      end
      if (memRdValid_o)
        stallEdges++;
      cycleNo++;
    end
  end

  // read responses after 0 to 3 cycles
  initial
  begin : memReadModel
    int lat;
    forever
    begin
      @(posedge clk);
      #5;
      if (memRdValid_o)
      begin
        lat = $unsigned($random(seed)) % 4;
        repeat (lat)
        begin
          @(posedge clk);
          #5;
        end
        memRdData_i      = memModel[memRdAddr_o];
        memRdDataValid_i = 1'b1;
        @(posedge clk);
        #5;
        memRdDataValid_i = 1'b0;
      end
    end
  end

  initial
  begin : memWriteModel
    int lat;
    int pos;
    forever
    begin
      @(posedge clk);
      #5;
      if (memWrValid_o)
      begin
        assert (wrOrder.size() != 0) else reportProblem("memory write with no committed store");
        pos = wrOrder.pop_front();                    // program order
        assert (memWrAddr_o == opAddr[pos])
          else reportMismatch("memWrAddr_o", 32'(memWrAddr_o), 32'(opAddr[pos]));
        assert (memWrData_o == opData[pos])
          else reportMismatch("memWrData_o", memWrData_o, opData[pos]);
        lat = $unsigned($random(seed)) % 4;
        repeat (lat)
        begin
          @(posedge clk);
          #5;
        end
        memWrDone_i = 1'b1;
        @(posedge clk);
        #5;
        memWrDone_i = 1'b0;
        memModel[opAddr[pos]] = opData[pos];          // written at the done edge
        opFreed[pos] = 1'b1;
        stCnt--;
      end
    end
  end

  initial
  begin : watchdog
    #(watchdogLimit);
    $display("ERROR: run did not finish within %0d time units", watchdogLimit);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin : stimulus
    int   n;
    int   first;
    int   cnt;
    int   j;
    int   tmp;
    logic isLoad;
    int   order [maxBatch];
    reset            = 1'b1;
    dispatchValid_i  = 1'b0;
    dispatchIsLoad_i = 1'b0;
    agenValid_i      = 1'b0;
    agenIsLoad_i     = 1'b0;
    agenLsqId_i      = '0;
    agenAddr_i       = '0;
    agenData_i       = '0;
    commitLoad_i     = 1'b0;
    commitStore_i    = 1'b0;
    memRdData_i      = '0;
    memRdDataValid_i = 1'b0;
    memWrDone_i      = 1'b0;
    for (int a = 0; a < (1 << addrBits); a++)
      memModel[a] = 32'hc3a50000 ^ (32'(a) * 32'h00019e37);
    repeat (4) @(posedge clk);
    #5;
    reset = 1'b0;
    checkIdle();
    assert (!dispatchReady_o) else reportMismatch("dispatchReady_o", 32'(dispatchReady_o), 0);
    @(posedge clk);
    #5;
    assert (dispatchReady_o) else reportMismatch("dispatchReady_o", 32'(dispatchReady_o), 1);
    for (int b = 0; b < numBatches; b++)
    begin
      first = opCount;
      n     = 4 + $unsigned($random(seed)) % 14;
      for (int k = 0; k < n; k++)
      begin
        isLoad = ($random(seed) & 1) != 0;
        if (isLoad && ldCnt == lqSize)
        begin
          dispatchOne(1'b1);                          // refused so try a store instead
          isLoad = 1'b0;
        end
        // full store queue ends the batch since a later load could not see all stores
        if (stCnt == sqSize)
        begin
          dispatchOne(1'b0);
          break;
        end
        dispatchOne(isLoad);
      end
      cnt = opCount - first;
      for (int i = 0; i < cnt; i++)
        order[i] = first + i;
      for (int i = cnt - 1; i > 0; i--)
      begin
        j        = $unsigned($random(seed)) % (i + 1);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
      for (int i = 0; i < cnt; i++)
      begin
        if (($random(seed) & 3) == 0)
        begin
          @(posedge clk);                             // idle gap
          #5;
        end
        sendAgen(order[i]);
      end
      while (wbCount != opCount)
      begin
        @(posedge clk);
        #5;
      end
      commitBatch(first, opCount);
      checkCounts();
    end
    checkIdle();
    assert (stallEdges > 0) else reportProblem("no memory read ever stalled the pipeline");
    assert (fwdCount > 0) else reportProblem("no load was forwarded from the store queue");
    assert (memLoadCount > 0) else reportProblem("no load read data memory");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- sources.f
lsuParamPkg.sv
lsuTypesPkg.sv
lsqAlloc.sv
storeQueue.sv
lsuAgenStage.sv
lsuForwardStage.sv
lsuMemStage.sv
lsuTop.sv
lsuTb.sv

//--- Makefile
# Verilator build and run of the load-store unit testbench
# a failing run ends in $fatal, so the sim target fails with it

TOP       ?= lsuTb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
